//--- hw/reorder_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes, payload types and the issue
// entry record of the read reorder block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package reorder_pkg;

    // Tag space, one tag per outstanding read
    localparam int unsigned NumTags  = 8;
    localparam int unsigned TagWidth = $clog2(NumTags);

    localparam int unsigned AddrWidth = 16;
    localparam int unsigned DataWidth = 32;

    typedef logic [TagWidth-1:0]  tag_t;
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;

    // Issue order record, tag in the upper bits
    typedef struct packed {
        tag_t  tag;
        addr_t addr;
    } issue_entry_t;

endpackage

//--- hw/tag_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free tag allocator, hands out
// the lowest unused tag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tag_queue #(
    parameter int unsigned NumTags = 8,
    parameter type         tag_t   = logic [$clog2(NumTags)-1:0]
) (
    input  logic clk_i,
    input  logic rst_ni,

    // Return path
    input  logic free_i,
    input  tag_t tag_i,

    // Claim path
    input  logic get_i,
    output logic valid_o,
    output tag_t tag_o
);

    logic [NumTags-1:0] used_q;
    logic [NumTags-1:0] used_d;
    tag_t               lowest_free;

    // At least one clear bit left
    assign valid_o = ~&used_q;

    // Scan from the top so the lowest clear bit wins
    always_comb begin
        lowest_free = '0;
        for (int i = NumTags - 1; i >= 0; i--) begin
            if (!used_q[i]) begin
                lowest_free = tag_t'(i);
            end
        end
    end

    assign tag_o = lowest_free;

    // Free and get may land in the same cycle
    always_comb begin
        used_d = used_q;
        if (free_i) begin
            used_d[tag_i] = 1'b0;
        end
        if (get_i && valid_o) begin
            used_d[lowest_free] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            used_q <= '0;
        end else begin
            used_q <= used_d;
        end
    end

    // Only an outstanding tag may come back
    free_in_use: assert property (@(posedge clk_i) disable iff (!rst_ni)
        free_i |-> used_q[tag_i])
        else $error("freed tag %0d is not in use", tag_i);

endmodule

//--- hw/issue_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read issue stage, claims a tag and
// sends the tagged memory request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_stage (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Client read strobe
    input  logic                      req_i,
    input  reorder_pkg::addr_t        req_addr_i,

    // Tag queue
    input  logic                      tag_valid_i,
    input  reorder_pkg::tag_t         tag_i,
    output logic                      get_o,

    // Issue order FIFO
    output logic                      push_o,
    output reorder_pkg::issue_entry_t push_entry_o,

    // Memory request
    output logic                      mem_req_o,
    output reorder_pkg::tag_t         mem_tag_o,
    output reorder_pkg::addr_t        mem_addr_o
);

    logic accept;

    // The tag queue decides and a strobe while busy is dropped
    assign get_o  = req_i;
    assign accept = req_i && tag_valid_i;

    assign push_o       = accept;
    assign push_entry_o = '{tag: tag_i, addr: req_addr_i};

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            mem_req_o <= 1'b0;
        end else begin
            mem_req_o <= accept;
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mem_tag_o  <= tag_i;
            mem_addr_o <= req_addr_i;
        end
    end

endmodule

//--- hw/issue_order_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular FIFO holding issued
// entries in request order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_order_fifo #(
    parameter int unsigned Depth   = 8,
    parameter type         entry_t = logic
) (
    input  logic   clk_i,
    input  logic   rst_ni,

    input  logic   push_i,
    input  entry_t push_entry_i,

    input  logic   pop_i,
    output entry_t head_o,
    output logic   empty_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    entry_t              mem_q [Depth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                full;

    // Wraps for any depth
    function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(Depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty_o = (count_q == '0);
    assign full    = (count_q == CntWidth'(Depth));
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

    no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full)
        else $error("push into full issue order FIFO");

    no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o)
        else $error("pop from empty issue order FIFO");

endmodule

//--- hw/response_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag indexed response store with
// in-order retirement
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module response_buffer (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Memory response
    input  logic                      rsp_i,
    input  reorder_pkg::tag_t         rsp_tag_i,
    input  reorder_pkg::data_t        rsp_data_i,

    // Issue order FIFO
    input  reorder_pkg::issue_entry_t head_i,
    input  logic                      empty_i,
    output logic                      pop_o,

    // Tag queue
    output logic                      free_o,
    output reorder_pkg::tag_t         free_tag_o,

    // Return to client
    output logic                      out_valid_o,
    output reorder_pkg::addr_t        out_addr_o,
    output reorder_pkg::data_t        out_data_o
);

    logic [reorder_pkg::NumTags-1:0] present_q;
    reorder_pkg::data_t              data_q [reorder_pkg::NumTags];
    reorder_pkg::tag_t               head_tag;
    logic                            retire;

    assign head_tag = head_i.tag;

    // Oldest read has its data
    assign retire = !empty_i && present_q[head_tag];

    assign pop_o      = retire;
    assign free_o     = retire;
    assign free_tag_o = head_tag;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            present_q   <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= retire;
            if (retire) begin
                present_q[head_tag] <= 1'b0;
            end
            // Never the retiring tag since that one already has its data
            if (rsp_i) begin
                present_q[rsp_tag_i] <= 1'b1;
            end
        end
    end

    // Response data
    always_ff @(posedge clk_i) begin
        if (rsp_i) begin
            data_q[rsp_tag_i] <= rsp_data_i;
        end
    end

    // Return payload
    always_ff @(posedge clk_i) begin
        if (retire) begin
            out_addr_o <= head_i.addr;
            out_data_o <= data_q[head_tag];
        end
    end

    // Exactly one response per issued tag
    rsp_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_i |-> !present_q[rsp_tag_i])
        else $error("second response for tag %0d", rsp_tag_i);

endmodule

//--- hw/read_reorder_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tagged read front end with
// in-order return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module read_reorder_top (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Client
    input  logic               req_i,
    input  reorder_pkg::addr_t req_addr_i,
    output logic               busy_o,

    // Memory side
    output logic               mem_req_o,
    output reorder_pkg::tag_t  mem_tag_o,
    output reorder_pkg::addr_t mem_addr_o,
    input  logic               rsp_i,
    input  reorder_pkg::tag_t  rsp_tag_i,
    input  reorder_pkg::data_t rsp_data_i,

    // Return
    output logic               out_valid_o,
    output reorder_pkg::addr_t out_addr_o,
    output reorder_pkg::data_t out_data_o
);

    logic                      tag_get;
    logic                      tag_valid;
    reorder_pkg::tag_t         claim_tag;
    logic                      tag_free;
    reorder_pkg::tag_t         free_tag;
    logic                      fifo_push;
    reorder_pkg::issue_entry_t fifo_push_entry;
    logic                      fifo_pop;
    reorder_pkg::issue_entry_t fifo_head;
    logic                      fifo_empty;

    // No free tag left
    assign busy_o = !tag_valid;

    tag_queue #(
        .NumTags (reorder_pkg::NumTags),
        .tag_t   (reorder_pkg::tag_t)
    ) tag_queue_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .free_i  (tag_free),
        .tag_i   (free_tag),
        .get_i   (tag_get),
        .valid_o (tag_valid),
        .tag_o   (claim_tag)
    );

    issue_stage issue_stage_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req_i),
        .req_addr_i   (req_addr_i),
        .tag_valid_i  (tag_valid),
        .tag_i        (claim_tag),
        .get_o        (tag_get),
        .push_o       (fifo_push),
        .push_entry_o (fifo_push_entry),
        .mem_req_o    (mem_req_o),
        .mem_tag_o    (mem_tag_o),
        .mem_addr_o   (mem_addr_o)
    );

    // One slot per tag, so the FIFO never overflows
    issue_order_fifo #(
        .Depth   (reorder_pkg::NumTags),
        .entry_t (reorder_pkg::issue_entry_t)
    ) issue_order_fifo_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (fifo_push),
        .push_entry_i (fifo_push_entry),
        .pop_i        (fifo_pop),
        .head_o       (fifo_head),
        .empty_o      (fifo_empty)
    );

    response_buffer response_buffer_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rsp_i       (rsp_i),
        .rsp_tag_i   (rsp_tag_i),
        .rsp_data_i  (rsp_data_i),
        .head_i      (fifo_head),
        .empty_i     (fifo_empty),
        .pop_o       (fifo_pop),
        .free_o      (tag_free),
        .free_tag_o  (free_tag),
        .out_valid_o (out_valid_o),
        .out_addr_o  (out_addr_o),
        .out_data_o  (out_data_o)
    );

endmodule

//--- tests/tb_mem_responder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory model answering pending
// requests out of order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mem_responder #(
    parameter int unsigned MaxDelay = 3
) (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Test controls
    input  logic               enable_i,
    input  logic               lifo_i,

    // Request from the DUT
    input  logic               mem_req_i,
    input  reorder_pkg::tag_t  mem_tag_i,
    input  reorder_pkg::addr_t mem_addr_i,

    // Response, data is formed from the address outside
    output logic               rsp_o,
    output reorder_pkg::tag_t  rsp_tag_o,
    output reorder_pkg::addr_t rsp_addr_o
);

    reorder_pkg::tag_t  pend_tag_q [$];
    reorder_pkg::addr_t pend_addr_q [$];
    logic               enable_q;
    logic               lifo_q;
    int unsigned        wait_cnt;
    int unsigned        pick;

    initial begin
        rsp_o      = 1'b0;
        rsp_tag_o  = '0;
        rsp_addr_o = '0;
        enable_q   = 1'b0;
        lifo_q     = 1'b0;
        wait_cnt   = 0;
    end

    // Requests and controls are taken mid cycle
    always @(negedge clk_i) begin
        enable_q = enable_i;
        lifo_q   = lifo_i;
        if (!rst_ni) begin
            pend_tag_q.delete();
            pend_addr_q.delete();
        end else if (mem_req_i) begin
            pend_tag_q.push_back(mem_tag_i);
            pend_addr_q.push_back(mem_addr_i);
        end
    end

    // One response at most per cycle, then a random gap
    always begin
        @(posedge clk_i);
        #1;
        rsp_o = 1'b0;
        if (wait_cnt != 0) begin
            wait_cnt--;
        end else if (enable_q && pend_tag_q.size() != 0) begin
            if (lifo_q) begin
                pick = pend_tag_q.size() - 1;
            end else begin
                pick = $urandom_range(pend_tag_q.size() - 1);
            end
            rsp_o      = 1'b1;
            rsp_tag_o  = pend_tag_q[pick];
            rsp_addr_o = pend_addr_q[pick];
            pend_tag_q.delete(pick);
            pend_addr_q.delete(pick);
            wait_cnt = $urandom_range(MaxDelay);
        end
    end

endmodule

//--- tests/tb_read_reorder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the read reorder
// block with scoreboard and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_read_reorder;

    localparam logic [31:0] Seed          = 32'h2b37_4ab6;
    localparam logic [31:0] DataPattern   = 32'hc3a5_5a3c;
    localparam int unsigned StressReqs    = 200;
    // Tests 2 to 5 together
    localparam int unsigned TotalReqs     = 4 + 6 + 9 + StressReqs;
    localparam int unsigned TimeoutCycles = 20 * TotalReqs + 200;

    logic               clk;
    logic               rst_n;
    logic               req;
    reorder_pkg::addr_t req_addr;
    logic               busy;
    logic               mem_req;
    reorder_pkg::tag_t  mem_tag;
    reorder_pkg::addr_t mem_addr;
    logic               rsp;
    reorder_pkg::tag_t  rsp_tag;
    reorder_pkg::addr_t rsp_addr;
    reorder_pkg::data_t rsp_data;
    logic               out_valid;
    reorder_pkg::addr_t out_addr;
    reorder_pkg::data_t out_data;
    logic               rsp_enable;
    logic               rsp_lifo;

    // Scoreboard queues of accepted reads and outstanding reads in order
    reorder_pkg::addr_t issue_q [$];
    reorder_pkg::addr_t ret_addr_q [$];
    reorder_pkg::tag_t  ret_tag_q [$];
    reorder_pkg::addr_t exp_addr;
    int unsigned        error_count = 0;
    int unsigned        test_base = 0;
    int unsigned        failed_tests = 0;
    int unsigned        return_count = 0;
    int unsigned        cycle_count = 0;
    int unsigned        base;
    int unsigned        issued;
    int unsigned        seed_dummy;

    function automatic reorder_pkg::data_t mem_word(input reorder_pkg::addr_t addr);
        return DataPattern ^ {addr, addr};
    endfunction

    read_reorder_top read_reorder_top_inst (
        .clk_i (clk), .rst_ni (rst_n),
        .req_i (req), .req_addr_i (req_addr), .busy_o (busy),
        .mem_req_o (mem_req), .mem_tag_o (mem_tag), .mem_addr_o (mem_addr),
        .rsp_i (rsp), .rsp_tag_i (rsp_tag), .rsp_data_i (rsp_data),
        .out_valid_o (out_valid), .out_addr_o (out_addr), .out_data_o (out_data)
    );

    tb_mem_responder mem_responder_inst (
        .clk_i (clk), .rst_ni (rst_n), .enable_i (rsp_enable), .lifo_i (rsp_lifo),
        .mem_req_i (mem_req), .mem_tag_i (mem_tag), .mem_addr_i (mem_addr),
        .rsp_o (rsp), .rsp_tag_o (rsp_tag), .rsp_addr_o (rsp_addr)
    );

    assign rsp_data = mem_word(rsp_addr);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic finish_test(input int num, input string name);
        if (error_count != test_base) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d errors", num, name, error_count - test_base);
        test_base = error_count;
    endtask

    // One cycle strobe that is expected to go through while not busy
    task automatic issue_read(input reorder_pkg::addr_t addr);
        req      = 1'b1;
        req_addr = addr;
        if (!busy) begin
            issue_q.push_back(addr);
        end
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic wait_drain();
        while (issue_q.size() != 0 || ret_addr_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Returns are checked first since a new request never reuses a retiring tag
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            return_count++;
            if (ret_addr_q.size() == 0) begin
                report_failure("out_valid_o with no outstanding read");
            end else begin
                exp_addr = ret_addr_q.pop_front();
                ret_tag_q.delete(0);
                if (out_addr !== exp_addr) begin
                    report_mismatch("out_addr_o", exp_addr, out_addr);
                end
                if (out_data !== mem_word(exp_addr)) begin
                    report_mismatch("out_data_o", mem_word(exp_addr), out_data);
                end
            end
        end
        if (rst_n && mem_req) begin
            if (issue_q.size() == 0) begin
                report_failure("mem_req_o without an accepted read");
            end else begin
                exp_addr = issue_q.pop_front();
                if (mem_addr !== exp_addr) begin
                    report_mismatch("mem_addr_o", exp_addr, mem_addr);
                end
                foreach (ret_tag_q[i]) begin
                    if (ret_tag_q[i] === mem_tag) begin
                        report_failure($sformatf("mem_tag_o %0d is still outstanding", mem_tag));
                    end
                end
                ret_addr_q.push_back(exp_addr);
                ret_tag_q.push_back(mem_tag);
            end
        end
    end

    initial begin
        wait (cycle_count >= TimeoutCycles);
        $display("Error: run did not finish within %0d cycles", TimeoutCycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed_dummy = $urandom(Seed);
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = 1'b0;
        req_addr   = '0;
        rsp_enable = 1'b0;
        rsp_lifo   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        if (mem_req !== 1'b0) begin
            report_mismatch("mem_req_o", 0, mem_req);
        end
        if (out_valid !== 1'b0) begin
            report_mismatch("out_valid_o", 0, out_valid);
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy_o", 0, busy);
        end
        @(posedge clk);
        #1;
        finish_test(1, "reset state");

        rsp_enable = 1'b1;
        repeat (4) issue_read($urandom);
        wait_drain();
        finish_test(2, "tagged requests");

        // Collect six and answer newest first
        rsp_enable = 1'b0;
        rsp_lifo   = 1'b1;
        for (int i = 0; i < 6; i++) begin
            issue_read(16'h1000 + 16'(i * 4));
        end
        rsp_enable = 1'b1;
        wait_drain();
        rsp_lifo = 1'b0;
        finish_test(3, "reverse responses");

        rsp_enable = 1'b0;
        for (int i = 0; i < 8; i++) begin
            issue_read(16'h2000 + 16'(i));
        end
        if (busy !== 1'b1) begin
            report_mismatch("busy_o", 1, busy);
        end
        base = return_count;
        issue_read(16'h2fff);
        repeat (4) @(posedge clk);
        #1;
        if (return_count != base) begin
            report_failure("a read returned while no response was given");
        end
        rsp_enable = 1'b1;
        while (return_count == base) begin
            @(posedge clk);
            #1;
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy_o", 0, busy);
        end
        issue_read(16'h3000);
        wait_drain();
        finish_test(4, "tag exhaustion");

        base   = return_count;
        issued = 0;
        while (issued < StressReqs) begin
            if (!busy && $urandom_range(3) != 0) begin
                issue_read($urandom);
                issued++;
            end else begin
                @(posedge clk);
                #1;
            end
        end
        wait_drain();
        if (return_count - base != StressReqs) begin
            report_failure($sformatf("%0d of %0d stress reads returned",
                                     return_count - base, StressReqs));
        end
        finish_test(5, "random stress");

        $display("5 tests, %0d failing, %0d errors", failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/reorder_pkg.sv
hw/tag_queue.sv
hw/issue_stage.sv
hw/issue_order_fifo.sv
hw/response_buffer.sv
hw/read_reorder_top.sv
tests/tb_mem_responder.sv
tests/tb_read_reorder.sv
